// ==== hilbertCoeffRom.sv ====
`timescale 1ns/100ps

module hilbertCoeffRom (
	input  logic                                     clock,
	input  logic                                     rstN,
	input  logic                                     loadCoeff,
	output logic signed [hilbertPkg::dataWidth-1:0] coeffOut,
	output logic                                     coeffSetFlag
);

	// Table address.
	// It counts down from the last entry to entry 0 while a load is in progress.
	logic [hilbertPkg::countWidth-1:0] index;

	// Set once entry 0 has gone out, so the completion pulse lasts one clock
	// even if the load level is held high afterwards.
	logic loadFinished;

	// The table is a constant, so the lookup is plain combinational logic.
	// The filter samples this word on the same edge that moves the index.
	assign coeffOut = hilbertPkg::coeffTable[index];

	// Entry 0 is on the bus in this cycle, so this is the last shift of the load.
	assign coeffSetFlag = loadCoeff && (index == '0) && !loadFinished;

	always_ff @(posedge clock) begin
		if (!rstN) begin
			index <= hilbertPkg::lastIndex;
			loadFinished <= 1'b0;
		end else if (!loadCoeff) begin
			// Rearm between loads.
			// Every new load starts again from the last entry.
			index <= hilbertPkg::lastIndex;
			loadFinished <= 1'b0;
		end else if (index != '0) begin
			index <= index - 1'b1;
		end else begin
			// Hold at entry 0 until the load level drops.
			loadFinished <= 1'b1;
		end
	end

	// The top level leaves the load state on the pulse.
	// A second pulse would mean the sequencer restarted without being rearmed.
	assert property (@(posedge clock) disable iff (!rstN)
		coeffSetFlag |=> !coeffSetFlag)
		else $error("coeffSetFlag was high for two consecutive cycles");

endmodule

// ==== hilbertFir.sv ====
`timescale 1ns/100ps

module hilbertFir (
	input  logic                                      clock,
	input  logic                                      rstN,
	input  logic                                      loadCoefficients,
	input  logic signed [hilbertPkg::dataWidth-1:0]  coeffIn,
	input  logic                                      loadDataFlag,
	input  logic signed [hilbertPkg::inputWidth-1:0] sampleIn,
	output logic signed [hilbertPkg::dataWidth-1:0]  dataOut,
	output logic signed [hilbertPkg::dataWidth-1:0]  centreTap
);

	// Coefficient chain.
	// Position i multiplies tap i once a full load has been shifted in.
	logic signed [hilbertPkg::dataWidth-1:0] coeffChain [0:hilbertPkg::tapCount-1];

	// Sample history.
	// Tap 0 holds the newest sample and tap tapCount-1 the oldest.
	logic signed [hilbertPkg::inputWidth-1:0] taps [0:hilbertPkg::tapCount-1];

	// Full-precision convolution result and its rescaled form.
	logic signed [hilbertPkg::accWidth-1:0] productSum;
	logic signed [hilbertPkg::accWidth-1:0] scaledSum;

	// The sequencer sends the last table entry first.
	// New words enter at position 0 and move up, so entry i ends in position i
	// after tapCount shifts.
	always_ff @(posedge clock) begin
		if (loadCoefficients) begin
			coeffChain[0] <= coeffIn;
			for (int i = 1; i < hilbertPkg::tapCount; i++) begin
				coeffChain[i] <= coeffChain[i - 1];
			end
		end
	end

	// The history is cleared on reset and again during every coefficient load.
	// Flushing leaves the oldest real sample in the last tap, and a new run
	// must start from an empty history.
	// The history only moves when a sample is actually taken.
	always_ff @(posedge clock) begin
		if (!rstN) begin
			for (int i = 0; i < hilbertPkg::tapCount; i++) begin
				taps[i] <= '0;
			end
		end else if (loadCoefficients) begin
			for (int i = 0; i < hilbertPkg::tapCount; i++) begin
				taps[i] <= '0;
			end
		end else if (loadDataFlag) begin
			taps[0] <= sampleIn;
			for (int i = 1; i < hilbertPkg::tapCount; i++) begin
				taps[i] <= taps[i - 1];
			end
		end
	end

	// Parallel multiply-accumulate over all taps.
	// Operands are sign-extended to the accumulator width before multiplying,
	// so no product or partial sum can overflow.
	always_comb begin
		productSum = '0;
		for (int i = 0; i < hilbertPkg::tapCount; i++) begin
			productSum = productSum + taps[i] * coeffChain[i];
		end
	end

	// Drop the coefficient fraction bits with an arithmetic shift.
	// The result is then truncated to the output width.
	assign scaledSum = productSum >>> hilbertPkg::coeffFrac;

	// Registered outputs, one clock behind the history.
	// The centre tap is the input delayed by the group delay.
	// It is the real part that leaves alongside the filtered imaginary part.
	always_ff @(posedge clock) begin
		if (!rstN) begin
			dataOut <= '0;
			centreTap <= '0;
		end else begin
			dataOut <= scaledSum[hilbertPkg::dataWidth-1:0];
			centreTap <= {
				{(hilbertPkg::dataWidth - hilbertPkg::inputWidth)
					{taps[hilbertPkg::groupDelay][hilbertPkg::inputWidth-1]}},
				taps[hilbertPkg::groupDelay]
			};
		end
	end

	// The top level must never stream samples while coefficients are loading.
	// Otherwise the history clear would fight the sample shift.
	assert property (@(posedge clock) disable iff (!rstN)
		!(loadCoefficients && loadDataFlag))
		else $error("coefficient load and sample load were active together");

	// Once sampling starts the coefficient chain must stay frozen.
	// Sampling may only follow a load or continue a run.
	assert property (@(posedge clock) disable iff (!rstN)
		$rose(loadDataFlag) |-> $past(loadCoefficients))
		else $error("sampling started without a coefficient load just before");

endmodule

// ==== hilbertPkg.sv ====
package hilbertPkg;

	// Number of filter taps. An odd count gives the filter an integer group delay.
	localparam int tapCount = 27;

	// Group delay of the filter in samples, which is also the index of the centre tap.
	localparam int groupDelay = (tapCount - 1) / 2;

	// Width of a signed input sample.
	localparam int inputWidth = 8;

	// Width of a signed output word and of a signed coefficient.
	localparam int dataWidth = 18;

	// Number of fraction bits carried by each coefficient.
	localparam int coeffFrac = 16;

	// Width of an index into the tap arrays, also used by the flush counter.
	localparam int countWidth = $clog2(tapCount);

	// Width of the full-precision sum of products.
	// It holds every product plus the growth from adding tapCount of them.
	localparam int accWidth = inputWidth + dataWidth + countWidth;

	// Index of the last table entry, where a coefficient load starts.
	localparam logic [countWidth-1:0] lastIndex = countWidth'(tapCount - 1);

	// Last value of the flush counter, so that tapCount-1 zeros are fed.
	localparam logic [countWidth-1:0] flushLast = countWidth'(tapCount - 2);

	// Hamming-windowed ideal Hilbert taps, 2/(pi*n) for odd offsets n from the centre.
	// Quantized with coeffFrac fraction bits.
	// Entries at the centre and at even offsets are zero, and the table is antisymmetric.
	// The sum of magnitudes is below 2.0, so a full-scale input cannot overflow dataWidth.
	localparam logic signed [dataWidth-1:0] coeffTable [0:tapCount-1] = '{
		-18'sd257,   18'sd0, -18'sd503,   18'sd0, -18'sd1292,  18'sd0,
		-18'sd2888,  18'sd0, -18'sd5867,  18'sd0, -18'sd12298, 18'sd0,
		-18'sd41164, 18'sd0,  18'sd41164, 18'sd0,  18'sd12298, 18'sd0,
		 18'sd5867,  18'sd0,  18'sd2888,  18'sd0,  18'sd1292,  18'sd0,
		 18'sd503,   18'sd0,  18'sd257
	};

	// Width of the top-level state register.
	localparam int stateWidth = 3;

	// Top-level states.
	// The machine waits in idle, loads coefficients, streams samples,
	// flushes the tail of the convolution and then reports completion in stop.
	localparam logic [stateWidth-1:0] idle      = 3'd0;
	localparam logic [stateWidth-1:0] loadCoeff = 3'd1;
	localparam logic [stateWidth-1:0] run       = 3'd2;
	localparam logic [stateWidth-1:0] flush     = 3'd3;
	localparam logic [stateWidth-1:0] stop      = 3'd4;

endpackage

// ==== hilbertTransform.f ====
hilbertPkg.sv
hilbertCoeffRom.sv
hilbertFir.sv
hilbertTransform.sv
tbHilbertTransform.sv

// ==== hilbertTransform.sv ====
`timescale 1ns/100ps

module hilbertTransform (
	input  logic                                      clock,
	input  logic                                      rstN,
	input  logic                                      enable,
	input  logic                                      stopDataInFlag,
	input  logic signed [hilbertPkg::inputWidth-1:0] dataIn,
	output logic signed [hilbertPkg::dataWidth-1:0]  dataOutRe,
	output logic signed [hilbertPkg::dataWidth-1:0]  dataOutIm,
	output logic                                      dataValid,
	output logic                                      done
);

	logic [hilbertPkg::stateWidth-1:0] state;

	// Coefficient load handshake with the sequencer.
	logic                                     loadCoeff;
	logic                                     coeffSetFlag;
	logic signed [hilbertPkg::dataWidth-1:0] coeffOut;

	// Sample path into the filter.
	logic                                      loadDataFlag;
	logic signed [hilbertPkg::inputWidth-1:0] sampleIn;

	// Registered filter results.
	logic signed [hilbertPkg::dataWidth-1:0] firOut;
	logic signed [hilbertPkg::dataWidth-1:0] centreTap;

	// Number of zero samples already fed during the flush.
	logic [hilbertPkg::countWidth-1:0] flushCount;

	// Set on the edge that takes a sample into the filter.
	// The filter registers the result of that sample on the following edge.
	logic sampleTaken;

	// Both levels follow the state register directly.
	// They change on the same edge as the state.
	assign loadCoeff = (state == hilbertPkg::loadCoeff);
	assign loadDataFlag = (state == hilbertPkg::run) || (state == hilbertPkg::flush);

	// Real samples while running, zeros while flushing the tail.
	assign sampleIn = (state == hilbertPkg::run) ? dataIn : '0;

	// Outputs read zero whenever the machine rests in idle.
	assign dataOutIm = (state == hilbertPkg::idle) ? '0 : firOut;
	assign dataOutRe = (state == hilbertPkg::idle) ? '0 : centreTap;

	hilbertCoeffRom coefficients (
		.clock        (clock),
		.rstN         (rstN),
		.loadCoeff    (loadCoeff),
		.coeffOut     (coeffOut),
		.coeffSetFlag (coeffSetFlag)
	);

	hilbertFir firFilter (
		.clock            (clock),
		.rstN             (rstN),
		.loadCoefficients (loadCoeff),
		.coeffIn          (coeffOut),
		.loadDataFlag     (loadDataFlag),
		.sampleIn         (sampleIn),
		.dataOut          (firOut),
		.centreTap        (centreTap)
	);

	always_ff @(posedge clock) begin
		if (!rstN) begin
			state <= hilbertPkg::idle;
			flushCount <= '0;
			sampleTaken <= 1'b0;
			dataValid <= 1'b0;
			done <= 1'b0;
		end else begin
			// A sample taken on this edge is summed by the filter on the next edge.
			// Dropping enable abandons it, since the outputs go to zero.
			sampleTaken <= loadDataFlag && enable;

			// The result of a sample is on the outputs one clock after it is taken.
			dataValid <= sampleTaken && enable;

			// Done waits in stop until the last flushed result has been presented.
			done <= (state == hilbertPkg::stop) && !sampleTaken && enable;

			if (!enable) begin
				state <= hilbertPkg::idle;
			end else begin
				case (state)
					hilbertPkg::idle: begin
						state <= hilbertPkg::loadCoeff;
					end
					hilbertPkg::loadCoeff: begin
						if (coeffSetFlag) begin
							state <= hilbertPkg::run;
						end
					end
					hilbertPkg::run: begin
						// The sample on this edge is the last real one.
						if (stopDataInFlag) begin
							state <= hilbertPkg::flush;
							flushCount <= '0;
						end
					end
					hilbertPkg::flush: begin
						if (flushCount == hilbertPkg::flushLast) begin
							state <= hilbertPkg::stop;
						end else begin
							flushCount <= flushCount + 1'b1;
						end
					end
					hilbertPkg::stop: begin
						state <= hilbertPkg::stop;
					end
					default: begin
						state <= hilbertPkg::idle;
					end
				endcase
			end
		end
	end

	// Completion is only reported after the last flushed output has gone.
	assert property (@(posedge clock) disable iff (!rstN)
		!(done && dataValid))
		else $error("done and dataValid were high together");

	// Every valid output belongs to a sample taken two cycles before.
	// Its result was registered by the filter in the cycle in between.
	assert property (@(posedge clock) disable iff (!rstN)
		dataValid |-> $past(loadDataFlag, 2))
		else $error("dataValid without a sample taken two cycles before");

endmodule

// ==== run.sh ====
#!/bin/sh
# Builds the Hilbert transformer testbench with Verilator and runs it.
# The exit status is the simulator's own status.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tbHilbertTransform \
	-f hilbertTransform.f \
	-Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit $status
fi

./obj_dir/VtbHilbertTransform
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation failed with status $status"
fi
exit $status

// ==== tbHilbertTransform.sv ====
`timescale 1ns/100ps

module tbHilbertTransform;

	// Longest any wait may last, in clock cycles.
	localparam int timeoutCycles = 200;
	localparam int randomCount = 100;
	localparam logic signed [hilbertPkg::inputWidth-1:0] impulseValue = 8'sd64;

	// Zero samples the DUT has taken by the time its first valid output is seen.
	// The first is summed on the edge that raises dataValid, which also takes the second.
	localparam int leadZeros = 2;

	logic                                      clock;
	logic                                      rstN;
	logic                                      enable;
	logic                                      stopDataInFlag;
	logic signed [hilbertPkg::inputWidth-1:0] dataIn;
	logic signed [hilbertPkg::dataWidth-1:0]  dataOutRe;
	logic signed [hilbertPkg::dataWidth-1:0]  dataOutIm;
	logic                                      dataValid;
	logic                                      done;

	// Samples of the current run, in the order in which the DUT takes them.
	// Flush zeros are not stored; reads past the end return zero.
	logic signed [hilbertPkg::inputWidth-1:0] history [$];
	int validCount;
	logic impulseRun;
	logic [31:0] lfsrState;

	hilbertTransform i_dut (
		.clock          (clock),
		.rstN           (rstN),
		.enable         (enable),
		.stopDataInFlag (stopDataInFlag),
		.dataIn         (dataIn),
		.dataOutRe      (dataOutRe),
		.dataOutIm      (dataOutIm),
		.dataValid      (dataValid),
		.done           (done)
	);

	initial begin
		clock = 1'b0;
		forever begin
			#20 clock = ~clock;
		end
	end

	// One step of a 32-bit Galois LFSR (x^32 + x^22 + x^2 + x + 1).
	function automatic logic [31:0] lfsrNext(input logic [31:0] current);
		if (current[0]) begin
			return (current >> 1) ^ 32'h8020_0003;
		end
		return current >> 1;
	endfunction

	// Builds a sample from eight LFSR output bits, one step per bit.
	task automatic drawSample(output logic signed [hilbertPkg::inputWidth-1:0] sample);
		sample = '0;
		for (int b = 0; b < hilbertPkg::inputWidth; b++) begin
			sample = {sample[hilbertPkg::inputWidth-2:0], lfsrState[0]};
			lfsrState = lfsrNext(lfsrState);
		end
	endtask

	// Sample at a history position, with zeros before the start and after the end.
	function automatic logic signed [hilbertPkg::inputWidth-1:0] sampleAt(input int position);
		if (position < 0 || position >= history.size()) begin
			return '0;
		end
		return history[position];
	endfunction

	// Valid output k reflects history entries k down to k-tapCount+1.
	// The convolution is exact and is then scaled by the coefficient fraction bits.
	function automatic logic signed [hilbertPkg::dataWidth-1:0] expectedIm(input int k);
		longint acc;
		longint scaled;
		acc = 0;
		for (int i = 0; i < hilbertPkg::tapCount; i++) begin
			acc += longint'(hilbertPkg::coeffTable[i]) * longint'(sampleAt(k - i));
		end
		scaled = acc >>> hilbertPkg::coeffFrac;
		return scaled[hilbertPkg::dataWidth-1:0];
	endfunction

	// The real part is the input delayed by the group delay, sign-extended.
	function automatic logic signed [hilbertPkg::dataWidth-1:0] expectedRe(input int k);
		logic signed [hilbertPkg::dataWidth-1:0] delayed;
		delayed = sampleAt(k - hilbertPkg::groupDelay);
		return delayed;
	endfunction

	// Response of tap offset to a lone impulse.
	// The centre and even offsets from it must be zero for a Hilbert filter.
	function automatic logic signed [hilbertPkg::dataWidth-1:0] impulseTap(input int offset);
		longint product;
		if ((offset - hilbertPkg::groupDelay) % 2 == 0) begin
			return '0;
		end
		product = longint'(impulseValue) * longint'(hilbertPkg::coeffTable[offset]);
		product = product >>> hilbertPkg::coeffFrac;
		return product[hilbertPkg::dataWidth-1:0];
	endfunction

	task automatic abortRun(input string reason);
		$display("TEST FAILED");
		$fatal(1, "%s", reason);
	endtask

	task automatic checkWord(input logic signed [hilbertPkg::dataWidth-1:0] actual,
			input logic signed [hilbertPkg::dataWidth-1:0] expected, input string what);
		if (actual !== expected) begin
			$display("FAILED at %0t ns: %s is %0d, expected %0d", $time, what, actual, expected);
			abortRun({what, " has a wrong value"});
		end
	endtask

	task automatic checkFlag(input logic actual, input logic expected, input string what);
		if (actual !== expected) begin
			$display("FAILED at %0t ns: %s is %b, expected %b", $time, what, actual, expected);
			abortRun({what, " has a wrong level"});
		end
	endtask

	task automatic checkCount(input int actual, input int expected, input string what);
		if (actual != expected) begin
			$display("FAILED at %0t ns: %s is %0d, expected %0d", $time, what, actual, expected);
			abortRun({what, " has a wrong count"});
		end
	endtask

	// In idle every output of the DUT rests at zero.
	task automatic checkIdle();
		checkFlag(dataValid, 1'b0, "dataValid in idle");
		checkFlag(done, 1'b0, "done in idle");
		checkWord(dataOutRe, '0, "dataOutRe in idle");
		checkWord(dataOutIm, '0, "dataOutIm in idle");
	endtask

	// One enable session: load, stream, flush, stop, then back to idle.
	task automatic runSession(input logic withImpulse);
		logic signed [hilbertPkg::inputWidth-1:0] sample;
		int waited;
		history.delete();
		validCount = 0;
		impulseRun = withImpulse;
		// The input rests at zero until the first valid output shows that sampling began.
		repeat (leadZeros) begin
			history.push_back('0);
		end
		if (withImpulse) begin
			history.push_back(impulseValue);
			for (int i = 1; i <= hilbertPkg::tapCount; i++) begin
				history.push_back('0);
			end
		end
		for (int i = 0; i < randomCount; i++) begin
			drawSample(sample);
			history.push_back(sample);
		end

		@(negedge clock);
		enable = 1'b1;
		dataIn = '0;
		waited = 0;
		while (!dataValid) begin
			@(negedge clock);
			waited++;
			if (waited > timeoutCycles) begin
				abortRun("no valid output appeared after enable, coefficient load stuck");
			end
		end

		// One new sample per clock; the stop request rides with the last one.
		for (int j = leadZeros; j < history.size(); j++) begin
			dataIn = history[j];
			stopDataInFlag = (j == history.size() - 1);
			@(negedge clock);
		end
		stopDataInFlag = 1'b0;
		dataIn = '0;

		waited = 0;
		while (!done) begin
			@(negedge clock);
			waited++;
			if (waited > timeoutCycles) begin
				abortRun("done never went high after the flush");
			end
		end
		checkCount(validCount, history.size() + hilbertPkg::tapCount - 1, "valid outputs");
		repeat (3) begin
			checkFlag(dataValid, 1'b0, "dataValid after done");
			checkFlag(done, 1'b1, "done in stop");
			@(negedge clock);
		end

		enable = 1'b0;
		@(negedge clock);
		checkIdle();
	endtask

	// Compares every valid output against the reference model.
	always @(posedge clock) begin
		if (rstN && dataValid) begin
			checkFlag(done, 1'b0, "done during a valid output");
			checkWord(dataOutIm, expectedIm(validCount), "dataOutIm");
			checkWord(dataOutRe, expectedRe(validCount), "dataOutRe");
			if (impulseRun && validCount >= leadZeros
					&& validCount < leadZeros + hilbertPkg::tapCount) begin
				checkWord(dataOutIm, impulseTap(validCount - leadZeros), "impulse response");
			end
			validCount++;
		end
	end

	initial begin
		rstN = 1'b0;
		enable = 1'b0;
		stopDataInFlag = 1'b0;
		dataIn = '0;
		validCount = 0;
		impulseRun = 1'b0;
		lfsrState = 32'h6835_8465;
		repeat (5) @(posedge clock);
		@(negedge clock);
		rstN = 1'b1;
		repeat (3) begin
			@(negedge clock);
			checkIdle();
		end
		// First session starts with an impulse, the second reloads with fresh data.
		runSession(1'b1);
		repeat (3) begin
			@(negedge clock);
			checkIdle();
		end
		runSession(1'b0);
		$display("TEST OK");
		$finish;
	end

endmodule
